// ==== addsub_sched.sv ====
`default_nettype none
`timescale 1ns/10ps

module addsub_sched #(
    parameter int SLOT_WORDS = kyber_ctrl_pkg::DEFAULT_SLOT_WORDS
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [kyber_ctrl_pkg::CNT_W-1:0]  cycle_cnt,
    input  wire logic                              running,
    output logic                                   addsub_start,
    output logic                                   add_flag,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]       addsub_ram_r_offset_a,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]       addsub_ram_r_offset_b
);

    typedef enum logic [1:0] {
        AS_NONE = 2'd0,
        AS_ADD  = 2'd1,
        AS_SUB  = 2'd2
    } addsub_step_t;

    addsub_step_t step;
    logic [2:0]   b_slot;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= AS_NONE;
        end else if (!running) begin
            step <= AS_NONE;
        end else if (cycle_cnt == kyber_ctrl_pkg::ADDSUB_STEP_CYC[0]) begin
            step <= AS_ADD; // s*u partial sums
        end else if (cycle_cnt == kyber_ctrl_pkg::ADDSUB_STEP_CYC[1]) begin
            step <= AS_SUB; // v minus s*u
        end
    end

    assign addsub_start = running &&
        (cycle_cnt == kyber_ctrl_pkg::ADDSUB_START_CYC[0] ||
         cycle_cnt == kyber_ctrl_pkg::ADDSUB_START_CYC[1]);

    assign add_flag = (step == AS_ADD);

    always_comb begin
        case (step)
            AS_ADD:  b_slot = 3'd1;
            AS_SUB:  b_slot = 3'd2;
            default: b_slot = 3'd0;
        endcase
    end

    assign addsub_ram_r_offset_a = kyber_ctrl_pkg::slot_offset(3'd0, SLOT_WORDS); // Always slot 0
    assign addsub_ram_r_offset_b = kyber_ctrl_pkg::slot_offset(b_slot, SLOT_WORDS);

endmodule

`default_nettype wire

// ==== coder_sched.sv ====
`default_nettype none
`timescale 1ns/10ps

module coder_sched (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [kyber_ctrl_pkg::CNT_W-1:0]  cycle_cnt,
    input  wire logic                              running,
    output logic                                   coder_active,
    output logic                                   coder_load_input,
    output kyber_ctrl_pkg::coder_op_t              coder_mode
);

    typedef enum logic [1:0] {
        CS_DECODE_C  = 2'd0,
        CS_DECODE_SK = 2'd1,
        CS_ENCODE_M  = 2'd2
    } coder_step_t;

    coder_step_t step;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= CS_DECODE_C;
        end else if (!running) begin
            step <= CS_DECODE_C; // Ready for ciphertext at cycle 0
        end else if (cycle_cnt == kyber_ctrl_pkg::CODER_STEP_CYC[0]) begin
            step <= CS_DECODE_SK;
        end else if (cycle_cnt == kyber_ctrl_pkg::CODER_STEP_CYC[1]) begin
            step <= CS_ENCODE_M;
        end
    end

    assign coder_load_input = running && (cycle_cnt == '0);

    assign coder_active = running &&
        (cycle_cnt == kyber_ctrl_pkg::CODER_ACT_CYC[0] ||
         cycle_cnt == kyber_ctrl_pkg::CODER_ACT_CYC[1] ||
         cycle_cnt == kyber_ctrl_pkg::CODER_ACT_CYC[2]);

    always_comb begin
        if (!running) coder_mode = kyber_ctrl_pkg::CODER_NONE;
        else begin
            case (step)
                CS_DECODE_SK: coder_mode = kyber_ctrl_pkg::DEC_DECODE_SK;
                CS_ENCODE_M:  coder_mode = kyber_ctrl_pkg::DEC_ENCODE_M;
                default:      coder_mode = kyber_ctrl_pkg::DEC_DECODE_C;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dec_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module dec_ctrl #(
    parameter int SLOT_WORDS = kyber_ctrl_pkg::DEFAULT_SLOT_WORDS
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         start,
    output logic                              finish,

    output logic                              ntt_start,
    output kyber_ctrl_pkg::ntt_op_t           ntt_mode,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]  ntt_ram_r_offset_a,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]  ntt_ram_r_offset_b,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]  ntt_ram_w_offset,

    output logic                              addsub_start,
    output logic                              add_flag,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]  addsub_ram_r_offset_a,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]  addsub_ram_r_offset_b,

    output logic                              coder_active,
    output logic                              coder_load_input,
    output kyber_ctrl_pkg::coder_op_t         coder_mode,

    output kyber_ctrl_pkg::bus_owner_t        ram_r_owner,
    output kyber_ctrl_pkg::bus_owner_t        ram_w_owner
);

    logic [kyber_ctrl_pkg::CNT_W-1:0] cycle_cnt;
    logic                             running;

    dec_timer u_dec_timer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cycle_cnt (cycle_cnt),
        .running   (running),
        .finish    (finish)
    );

    ntt_sched #(.SLOT_WORDS(SLOT_WORDS)) u_ntt_sched (
        .clk                (clk),
        .rst                (rst),
        .cycle_cnt          (cycle_cnt),
        .running            (running),
        .ntt_start          (ntt_start),
        .ntt_mode           (ntt_mode),
        .ntt_ram_r_offset_a (ntt_ram_r_offset_a),
        .ntt_ram_r_offset_b (ntt_ram_r_offset_b),
        .ntt_ram_w_offset   (ntt_ram_w_offset)
    );

    addsub_sched #(.SLOT_WORDS(SLOT_WORDS)) u_addsub_sched (
        .clk                   (clk),
        .rst                   (rst),
        .cycle_cnt             (cycle_cnt),
        .running               (running),
        .addsub_start          (addsub_start),
        .add_flag              (add_flag),
        .addsub_ram_r_offset_a (addsub_ram_r_offset_a),
        .addsub_ram_r_offset_b (addsub_ram_r_offset_b)
    );

    coder_sched u_coder_sched (
        .clk              (clk),
        .rst              (rst),
        .cycle_cnt        (cycle_cnt),
        .running          (running),
        .coder_active     (coder_active),
        .coder_load_input (coder_load_input),
        .coder_mode       (coder_mode)
    );

    ram_bus_arb u_ram_bus_arb (
        .cycle_cnt   (cycle_cnt),
        .running     (running),
        .ram_r_owner (ram_r_owner),
        .ram_w_owner (ram_w_owner)
    );

endmodule

`default_nettype wire

// ==== dec_ctrl_sva.sv ====
`default_nettype none
`timescale 1ns/10ps

module dec_ctrl_sva (
    input wire logic                              clk,
    input wire logic                              rst,
    input wire logic                              start,
    input wire logic                              finish,
    input wire logic [kyber_ctrl_pkg::CNT_W-1:0]  cycle_cnt,
    input wire logic                              running,
    input wire logic                              ntt_start,
    input wire logic                              addsub_start,
    input wire logic                              coder_active,
    input wire logic                              coder_load_input,
    input wire kyber_ctrl_pkg::coder_op_t         coder_mode,
    input wire kyber_ctrl_pkg::bus_owner_t        ram_r_owner,
    input wire kyber_ctrl_pkg::bus_owner_t        ram_w_owner
);

    // Counter moves by one each cycle of a run whatever start does
    a_count_step: assert property (@(posedge clk) disable iff (rst)
        running && cycle_cnt != kyber_ctrl_pkg::DEC_LAST
        |=> running && cycle_cnt == $past(cycle_cnt) + 12'd1)
        else $error("cycle counter did not advance by one during a run");

    a_run_end: assert property (@(posedge clk) disable iff (rst)
        running && cycle_cnt == kyber_ctrl_pkg::DEC_LAST |=> finish && !running)
        else $error("run did not end after its last cycle");

    a_start_accept: assert property (@(posedge clk) disable iff (rst)
        !running && start |=> running && !finish && cycle_cnt == 12'd0)
        else $error("start while idle did not begin a run at cycle 0");

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !running |-> !(ntt_start || addsub_start || coder_active || coder_load_input)
        && coder_mode == kyber_ctrl_pkg::CODER_NONE
        && ram_r_owner == kyber_ctrl_pkg::OWNER_CODER
        && ram_w_owner == kyber_ctrl_pkg::OWNER_CODER)
        else $error("controller not quiet while idle");

    // Coder keeps the write port through the first NTT
    a_ntt_window: assert property (@(posedge clk) disable iff (rst)
        ntt_start |-> ram_r_owner == kyber_ctrl_pkg::OWNER_NTT
        && (ram_w_owner == kyber_ctrl_pkg::OWNER_NTT
            || (cycle_cnt < 12'd163 && ram_w_owner == kyber_ctrl_pkg::OWNER_CODER)))
        else $error("NTT started without owning the RAM");

    a_addsub_window: assert property (@(posedge clk) disable iff (rst)
        addsub_start |-> ram_r_owner == kyber_ctrl_pkg::OWNER_ADDSUB
        && ram_w_owner == kyber_ctrl_pkg::OWNER_ADDSUB)
        else $error("add/sub started without owning the RAM");

    a_engine_pulse: assert property (@(posedge clk) disable iff (rst)
        ntt_start || addsub_start |=> !ntt_start && !addsub_start)
        else $error("engine start strobe longer than one cycle");

    a_coder_window: assert property (@(posedge clk) disable iff (rst)
        coder_active |-> ram_w_owner == kyber_ctrl_pkg::OWNER_CODER
        && coder_mode != kyber_ctrl_pkg::CODER_NONE)
        else $error("coder activated without the write port or an operation");

    a_load_first: assert property (@(posedge clk) disable iff (rst)
        coder_load_input |-> coder_active && cycle_cnt == 12'd0
        && coder_mode == kyber_ctrl_pkg::DEC_DECODE_C)
        else $error("coder load strobe outside the first run cycle");

endmodule

bind dec_ctrl dec_ctrl_sva u_dec_ctrl_sva (.*);

`default_nettype wire

// ==== dec_timer.sv ====
`default_nettype none
`timescale 1ns/10ps

module dec_timer (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             start,
    output logic [kyber_ctrl_pkg::CNT_W-1:0]      cycle_cnt,
    output logic                                  running,
    output logic                                  finish
);

    kyber_ctrl_pkg::run_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= kyber_ctrl_pkg::ST_IDLE;
        end else begin
            case (state)
                kyber_ctrl_pkg::ST_IDLE: begin
                    if (start) state <= kyber_ctrl_pkg::ST_RUN; // Start ignored while running
                end
                default: begin
                    if (cycle_cnt == kyber_ctrl_pkg::DEC_LAST) begin
                        state <= kyber_ctrl_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else if (state == kyber_ctrl_pkg::ST_RUN && cycle_cnt != kyber_ctrl_pkg::DEC_LAST) begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end else begin
            cycle_cnt <= '0; // Held at 0 while idle
        end
    end

    assign running = (state == kyber_ctrl_pkg::ST_RUN);
    assign finish  = (state == kyber_ctrl_pkg::ST_IDLE);

endmodule

`default_nettype wire

// ==== files.f ====
kyber_ctrl_pkg.sv
dec_timer.sv
ntt_sched.sv
addsub_sched.sv
coder_sched.sv
ram_bus_arb.sv
dec_ctrl.sv
dec_ctrl_sva.sv
tb_dec_ctrl.sv

// ==== kyber_ctrl_pkg.sv ====
`default_nettype none

package kyber_ctrl_pkg;

    localparam int CNT_W = 12;
    localparam int OFS_W = 8;

    localparam int DEFAULT_SLOT_WORDS = 32; // Words per polynomial slot

    localparam logic [CNT_W-1:0] DEC_LAST = 12'd1174; // Run is 1175 cycles

    // NTT strobes and the cycles that load the matching step
    localparam logic [CNT_W-1:0] NTT_START_CYC [0:4] =
        '{12'd34, 12'd264, 12'd494, 12'd634, 12'd842};
    localparam logic [CNT_W-1:0] NTT_STEP_CYC [0:4] =
        '{12'd0, 12'd263, 12'd493, 12'd633, 12'd841};

    localparam logic [CNT_W-1:0] ADDSUB_START_CYC [0:1] = '{12'd774, 12'd1072};
    localparam logic [CNT_W-1:0] ADDSUB_STEP_CYC [0:1] = '{12'd773, 12'd1071};

    localparam logic [CNT_W-1:0] CODER_ACT_CYC [0:2] = '{12'd0, 12'd98, 12'd1140};
    localparam logic [CNT_W-1:0] CODER_STEP_CYC [0:1] = '{12'd97, 12'd1139};

    localparam logic [CNT_W-1:0] CODER_W_END = 12'd163; // Coder writes c before NTT

    typedef enum logic [1:0] {
        NTT_FWD = 2'd0,
        NTT_INV = 2'd1,
        NTT_MUL = 2'd2
    } ntt_op_t;

    typedef enum logic [3:0] {
        CODER_NONE    = 4'd0,
        DEC_DECODE_SK = 4'd6,
        DEC_DECODE_C  = 4'd7,
        DEC_ENCODE_M  = 4'd8
    } coder_op_t;

    typedef enum logic [1:0] {
        OWNER_CODER  = 2'd0,
        OWNER_NTT    = 2'd1,
        OWNER_ADDSUB = 2'd2
    } bus_owner_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } run_state_t;

    // Start word of a polynomial slot in the shared RAM
    function automatic logic [OFS_W-1:0] slot_offset(
        input logic [2:0] slot,
        input int         words
    );
        logic [31:0] full;
        full = {29'd0, slot} * words;
        return full[OFS_W-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== ntt_sched.sv ====
`default_nettype none
`timescale 1ns/10ps

module ntt_sched #(
    parameter int SLOT_WORDS = kyber_ctrl_pkg::DEFAULT_SLOT_WORDS
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [kyber_ctrl_pkg::CNT_W-1:0]  cycle_cnt,
    input  wire logic                              running,
    output logic                                   ntt_start,
    output kyber_ctrl_pkg::ntt_op_t                ntt_mode,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]       ntt_ram_r_offset_a,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]       ntt_ram_r_offset_b,
    output logic [kyber_ctrl_pkg::OFS_W-1:0]       ntt_ram_w_offset
);

    logic [2:0] step;
    logic       start_hit;
    logic [2:0] a_slot;
    logic [2:0] b_slot;
    logic [2:0] w_slot;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= 3'd0;
        end else if (!running) begin
            step <= 3'd0;
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (cycle_cnt == kyber_ctrl_pkg::NTT_STEP_CYC[i]) step <= 3'(i);
            end
        end
    end

    always_comb begin
        start_hit = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (cycle_cnt == kyber_ctrl_pkg::NTT_START_CYC[i]) start_hit = 1'b1;
        end
    end

    assign ntt_start = running && start_hit;

    // Step decode into operation and polynomial slots
    always_comb begin
        case (step)
            3'd1: begin
                ntt_mode = kyber_ctrl_pkg::NTT_FWD; // NTT of u1
                a_slot   = 3'd1;
                b_slot   = 3'd1;
                w_slot   = 3'd1;
            end
            3'd2: begin
                ntt_mode = kyber_ctrl_pkg::NTT_MUL; // s0 * u0
                a_slot   = 3'd0;
                b_slot   = 3'd3;
                w_slot   = 3'd0;
            end
            3'd3: begin
                ntt_mode = kyber_ctrl_pkg::NTT_MUL; // s1 * u1
                a_slot   = 3'd1;
                b_slot   = 3'd4;
                w_slot   = 3'd1;
            end
            3'd4: begin
                ntt_mode = kyber_ctrl_pkg::NTT_INV;
                a_slot   = 3'd0;
                b_slot   = 3'd0;
                w_slot   = 3'd0;
            end
            default: begin
                ntt_mode = kyber_ctrl_pkg::NTT_FWD; // NTT of u0
                a_slot   = 3'd0;
                b_slot   = 3'd0;
                w_slot   = 3'd0;
            end
        endcase
    end

    assign ntt_ram_r_offset_a = kyber_ctrl_pkg::slot_offset(a_slot, SLOT_WORDS);
    assign ntt_ram_r_offset_b = kyber_ctrl_pkg::slot_offset(b_slot, SLOT_WORDS);
    assign ntt_ram_w_offset   = kyber_ctrl_pkg::slot_offset(w_slot, SLOT_WORDS);

endmodule

`default_nettype wire

// ==== ram_bus_arb.sv ====
`default_nettype none
`timescale 1ns/10ps

module ram_bus_arb (
    input  wire logic [kyber_ctrl_pkg::CNT_W-1:0]  cycle_cnt,
    input  wire logic                              running,
    output kyber_ctrl_pkg::bus_owner_t             ram_r_owner,
    output kyber_ctrl_pkg::bus_owner_t             ram_w_owner
);

    kyber_ctrl_pkg::bus_owner_t win_owner;

    // Engine windows shared by both ports
    always_comb begin
        if (!running) begin
            win_owner = kyber_ctrl_pkg::OWNER_CODER;
        end else if (cycle_cnt < kyber_ctrl_pkg::ADDSUB_START_CYC[0]) begin
            win_owner = kyber_ctrl_pkg::OWNER_NTT;
        end else if (cycle_cnt < kyber_ctrl_pkg::NTT_START_CYC[4]) begin
            win_owner = kyber_ctrl_pkg::OWNER_ADDSUB;
        end else if (cycle_cnt < kyber_ctrl_pkg::ADDSUB_START_CYC[1]) begin
            win_owner = kyber_ctrl_pkg::OWNER_NTT; // Inverse NTT
        end else if (cycle_cnt < kyber_ctrl_pkg::CODER_ACT_CYC[2]) begin
            win_owner = kyber_ctrl_pkg::OWNER_ADDSUB;
        end else begin
            win_owner = kyber_ctrl_pkg::OWNER_CODER; // Message encode
        end
    end

    assign ram_r_owner = win_owner;

    // Coder fills the RAM with u and sk early in the run
    always_comb begin
        if (running && cycle_cnt < kyber_ctrl_pkg::CODER_W_END) begin
            ram_w_owner = kyber_ctrl_pkg::OWNER_CODER;
        end else begin
            ram_w_owner = win_owner;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the decryption controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_dec_ctrl \
    -Mdir obj_dir -f files.f
out=$(./obj_dir/Vtb_dec_ctrl || true)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$"

// ==== tb_dec_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_dec_ctrl;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES = 1175;
    localparam int NUM_RUNS = 3;
    localparam int GAP_MAX = 40;
    localparam int SLOT = 32;
    localparam int CODER_W_END = 163; // Coder owns the write port below this run cycle
    localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_CYCLES + (NUM_RUNS + 1) * GAP_MAX
                                     + RESET_CYCLES + 1000;

    // Decryption schedule in run cycles
    localparam int NTT_CYC [5] = '{34, 264, 494, 634, 842};
    localparam int NTT_OP [5] = '{0, 0, 2, 2, 1}; // FWD FWD MUL MUL INV
    localparam int NTT_A [5] = '{0, 1, 0, 1, 0};
    localparam int NTT_B [5] = '{0, 1, 3, 4, 0};
    localparam int NTT_W [5] = '{0, 1, 0, 1, 0};
    localparam int AS_CYC [2] = '{774, 1072};
    localparam int CODER_CYC [3] = '{0, 98, 1140};
    localparam int CODER_OP [3] = '{7, 6, 8}; // Decode c, decode sk, encode m

    logic clk;
    logic rst;
    logic start;
    logic finish;
    logic ntt_start;
    kyber_ctrl_pkg::ntt_op_t ntt_mode;
    logic [kyber_ctrl_pkg::OFS_W-1:0] ntt_ram_r_offset_a;
    logic [kyber_ctrl_pkg::OFS_W-1:0] ntt_ram_r_offset_b;
    logic [kyber_ctrl_pkg::OFS_W-1:0] ntt_ram_w_offset;
    logic addsub_start;
    logic add_flag;
    logic [kyber_ctrl_pkg::OFS_W-1:0] addsub_ram_r_offset_a;
    logic [kyber_ctrl_pkg::OFS_W-1:0] addsub_ram_r_offset_b;
    logic coder_active;
    logic coder_load_input;
    kyber_ctrl_pkg::coder_op_t coder_mode;
    kyber_ctrl_pkg::bus_owner_t ram_r_owner;
    kyber_ctrl_pkg::bus_owner_t ram_w_owner;

    string test_name [5] = '{"reset_idle", "run_length", "ntt_schedule",
                             "addsub_schedule", "coder_schedule"};
    int checks [5];
    int fails [5];
    logic tb_running; // Reference run state from accepted starts
    int tb_cnt;
    int seed;
    int gap;
    int failed_tests;

    dec_ctrl #(.SLOT_WORDS(SLOT)) u_dec_ctrl (.*);

    task automatic check_value(input int t, input string what, input int exp, input int act);
        checks[t]++;
        assert (act == exp) else begin
            $display("[FAIL] %0s %0s: expected %0d, actual %0d", test_name[t], what, exp, act);
            fails[t]++;
        end
    endtask

    task automatic check_idle();
        check_value(0, "finish", 1, int'(finish));
        check_value(0, "strobes", 0,
                    int'({ntt_start, addsub_start, coder_active, coder_load_input}));
        check_value(0, "coder_mode", 0, int'(coder_mode));
        check_value(0, "ram_r_owner", 0, int'(ram_r_owner));
        check_value(0, "ram_w_owner", 0, int'(ram_w_owner));
    endtask

    task automatic check_run_cycle(input int c);
        int k;
        check_value(1, "finish", 0, int'(finish));
        k = -1;
        for (int i = 0; i < 5; i++)
            if (c == NTT_CYC[i]) k = i;
        check_value(2, "ntt_start", int'(k >= 0), int'(ntt_start));
        if (k >= 0) begin
            check_value(2, "ntt_mode", NTT_OP[k], int'(ntt_mode));
            check_value(2, "offset_a", NTT_A[k] * SLOT, int'(ntt_ram_r_offset_a));
            check_value(2, "offset_b", NTT_B[k] * SLOT, int'(ntt_ram_r_offset_b));
            check_value(2, "offset_w", NTT_W[k] * SLOT, int'(ntt_ram_w_offset));
            check_value(2, "ram_r_owner", 1, int'(ram_r_owner));
            check_value(2, "ram_w_owner", (c < CODER_W_END) ? 0 : 1, int'(ram_w_owner));
        end
        k = -1;
        for (int i = 0; i < 2; i++)
            if (c == AS_CYC[i]) k = i;
        check_value(3, "addsub_start", int'(k >= 0), int'(addsub_start));
        if (k >= 0) begin
            check_value(3, "add_flag", int'(k == 0), int'(add_flag));
            check_value(3, "offset_a", 0, int'(addsub_ram_r_offset_a));
            check_value(3, "offset_b", (k + 1) * SLOT, int'(addsub_ram_r_offset_b)); // Slot 1 then 2
            check_value(3, "ram_r_owner", 2, int'(ram_r_owner));
            check_value(3, "ram_w_owner", 2, int'(ram_w_owner));
        end
        check_value(4, "coder_load_input", int'(c == 0), int'(coder_load_input));
        k = -1;
        for (int i = 0; i < 3; i++)
            if (c == CODER_CYC[i]) k = i;
        check_value(4, "coder_active", int'(k >= 0), int'(coder_active));
        if (k >= 0) begin
            check_value(4, "coder_mode", CODER_OP[k], int'(coder_mode));
            check_value(4, "ram_w_owner", 0, int'(ram_w_owner));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference model and checks on pre-edge DUT values
    always @(posedge clk) begin
        if (rst) begin
            tb_running = 1'b0;
            tb_cnt = 0;
        end else if (!tb_running) begin
            check_idle();
            if (start) begin
                tb_running = 1'b1;
                tb_cnt = 0;
            end
        end else begin
            check_run_cycle(tb_cnt);
            if (tb_cnt == RUN_CYCLES - 1) begin
                tb_running = 1'b0;
            end else begin
                tb_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the runs did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed = 32'h6386b21b;
        rst = 1'b1;
        start = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            gap = 8 + ($random(seed) & 31);
            repeat (gap) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            while (tb_running) begin
                start = (($random(seed) & 63) == 0); // Extra start while busy
                @(negedge clk);
            end
            start = 1'b0;
        end
        gap = 8 + ($random(seed) & 31);
        repeat (gap) @(negedge clk);
        failed_tests = 0;
        for (int t = 0; t < 5; t++) begin
            $display("Test %0s: %0s (%0d checks, %0d errors)", test_name[t],
                     (fails[t] == 0) ? "ok" : "failed", checks[t], fails[t]);
            if (fails[t] != 0) failed_tests++;
        end
        $display("Tests: %0d passed, %0d failed", 5 - failed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
